// File: game_pkg.sv
package game_pkg;

    // raster position from the timing counters
    typedef logic [9:0] raster_t;

    // sprite origin, signed so it can leave the screen on the left or top
    typedef logic signed [10:0] pos_x_t;
    typedef logic signed [9:0]  pos_y_t;

    // per-frame displacement
    typedef logic signed [7:0] vel_t;

    // one 4-bit colour channel of the vga dac
    typedef logic [3:0] chan_t;

    // sprite poses, one renderer each
    typedef enum logic [1:0] {
        walk_a = 2'd0,
        walk_b = 2'd1,
        jump   = 2'd2
    } pose_t;

    // pixels per frame while walking
    localparam int WALK_STEP = 2;
    // pixels per frame while jumping
    localparam int JUMP_STEP = 4;
    // frames going up, and again frames coming down
    localparam int JUMP_HALF_FRAMES = 20;
    // frames between walking pose swaps
    localparam int POSE_SWAP_FRAMES = 8;

endpackage

// File: vga_timing.sv
`timescale 1ns/1ps

module vga_timing #(
    parameter int H_ACTIVE_END = 639,
    parameter int H_FP_END     = 655,
    parameter int H_SYNC_END   = 751,
    parameter int H_TOTAL_END  = 799,
    parameter int V_ACTIVE_END = 479,
    parameter int V_FP_END     = 489,
    parameter int V_SYNC_END   = 491,
    parameter int V_TOTAL_END  = 520
) (
    input  logic              clk,
    input  logic              reset,
    output game_pkg::raster_t h_count,
    output game_pkg::raster_t v_count,
    output logic              frame_start,
    output logic              hsync,
    output logic              vsync
);
    import game_pkg::*;

    logic h_wrap;
    logic v_wrap;
    logic h_sync_win;
    logic v_sync_win;

    // last pixel of a line, last line of a frame
    assign h_wrap = (h_count == raster_t'(H_TOTAL_END));
    assign v_wrap = (v_count == raster_t'(V_TOTAL_END));

    // sync window lies in blanking, after the front porch
    assign h_sync_win = (h_count > raster_t'(H_ACTIVE_END)) &&
                        (h_count > raster_t'(H_FP_END)) &&
                        (h_count <= raster_t'(H_SYNC_END));
    assign v_sync_win = (v_count > raster_t'(V_ACTIVE_END)) &&
                        (v_count > V_FP_END) &&
                        (v_count <= V_SYNC_END);

    // pixel counter, line counter stepped at end of line
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            h_count <= '0;
            v_count <= '0;
        end
        else
        begin
            if (h_wrap)
            begin
                h_count <= '0;
                if (v_wrap)
                    v_count <= '0;
                else
                    v_count <= v_count + 1'b1;
            end
            else
            begin
                h_count <= h_count + 1'b1;
            end
        end
    end

    // sync active low, one cycle behind the counters
    // frame_start is high exactly while both counters read 0
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            hsync       <= 1'b1;
            vsync       <= 1'b1;
            frame_start <= 1'b0;
        end
        else
        begin
            hsync       <= ~h_sync_win;
            vsync       <= ~v_sync_win;
            frame_start <= h_wrap && v_wrap;
        end
    end

endmodule

// File: button_edges.sv
`timescale 1ns/1ps

module button_edges (
    input  logic clk,
    input  logic reset,
    input  logic jump_raw,
    input  logic right_raw,
    input  logic left_raw,
    input  logic stop_raw,
    output logic jump_press,
    output logic right_press,
    output logic left_press,
    output logic stop_press
);

    // bit order: jump, right, left, stop
    logic [3:0] raw;
    logic [3:0] sync_q1;
    logic [3:0] sync_q2;
    logic [3:0] rise;

    assign raw = {jump_raw, right_raw, left_raw, stop_raw};

    // two flop stages per button
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end
        else
        begin
            sync_q1 <= raw;
            sync_q2 <= sync_q1;
        end
    end

    // first stage high, second still low: a fresh press
    assign rise = sync_q1 & ~sync_q2;

    assign jump_press  = rise[3];
    assign right_press = rise[2];
    assign left_press  = rise[1];
    assign stop_press  = rise[0];

endmodule

// File: jump_control.sv
`timescale 1ns/1ps

module jump_control (
    input  logic            clk,
    input  logic            reset,
    input  logic            frame_start,
    input  logic            jump_press,
    output logic            jumping,
    output game_pkg::vel_t  vel_y,
    output game_pkg::pose_t pose
);
    import game_pkg::*;

    // counts 0..2*half, the last value ends the jump
    localparam int JUMP_CNT_W = $clog2(2 * JUMP_HALF_FRAMES + 1);
    localparam int SWAP_CNT_W = (POSE_SWAP_FRAMES > 1) ? $clog2(POSE_SWAP_FRAMES) : 1;

    logic [JUMP_CNT_W-1:0] jump_frames;
    logic [SWAP_CNT_W-1:0] swap_frames;
    logic                  jump_done;
    logic                  swap_now;

    // jump flag; presses while airborne are ignored
    always_ff @(posedge clk)
    begin
        if (reset)
            jumping <= 1'b0;
        else if (jump_done)
            jumping <= 1'b0;
        else if (jump_press)
            jumping <= 1'b1;
    end

    // rise phase, fall phase, then land
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            jump_frames <= '0;
            vel_y       <= '0;
            jump_done   <= 1'b0;
        end
        else
        begin
            jump_done <= 1'b0;
            if (!jumping)
            begin
                jump_frames <= '0;
                vel_y       <= '0;
            end
            else if (frame_start)
            begin
                if (jump_frames < JUMP_HALF_FRAMES)
                begin
                    // screen y grows downwards, so up is negative
                    jump_frames <= jump_frames + 1'b1;
                    vel_y       <= vel_t'(-JUMP_STEP);
                end
                else if (jump_frames < 2 * JUMP_HALF_FRAMES)
                begin
                    jump_frames <= jump_frames + 1'b1;
                    vel_y       <= vel_t'(JUMP_STEP);
                end
                else
                begin
                    jump_frames <= '0;
                    vel_y       <= '0;
                    jump_done   <= 1'b1;
                end
            end
        end
    end

    // frame counter modulo the swap period
    always_ff @(posedge clk)
    begin
        if (reset)
            swap_frames <= '0;
        else if (frame_start)
        begin
            if (swap_frames == SWAP_CNT_W'(POSE_SWAP_FRAMES - 1))
                swap_frames <= '0;
            else
                swap_frames <= swap_frames + 1'b1;
        end
    end

    assign swap_now = frame_start && (swap_frames == '0);

    // pose pick; landing forces walk_a
    always_ff @(posedge clk)
    begin
        if (reset)
            pose <= walk_a;
        else if (jump_done)
            pose <= walk_a;
        else if (swap_now)
        begin
            if (jumping)
                pose <= jump;
            else if (pose == walk_a)
                pose <= walk_b;
            else
                pose <= walk_a;
        end
    end

endmodule

// File: sprite_motion.sv
`timescale 1ns/1ps

module sprite_motion #(
    parameter int START_LEFT = 300,
    parameter int START_TOP  = 250
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             frame_start,
    input  logic             right_press,
    input  logic             left_press,
    input  logic             stop_press,
    input  game_pkg::vel_t   vel_y,
    output game_pkg::pos_x_t left,
    output game_pkg::pos_y_t top
);
    import game_pkg::*;

    vel_t vel_x;

    // walking direction, latched from the last press
    // right wins over left, left over stop
    always_ff @(posedge clk)
    begin
        if (reset)
            vel_x <= '0;
        else if (right_press)
            vel_x <= vel_t'(WALK_STEP);
        else if (left_press)
            vel_x <= vel_t'(-WALK_STEP);
        else if (stop_press)
            vel_x <= '0;
    end

    // position moves once per frame, at the raster origin
    // vel_y is sampled before jump_control updates it
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            left <= pos_x_t'(START_LEFT);
            top  <= pos_y_t'(START_TOP);
        end
        else if (frame_start)
        begin
            // signed operands, velocity sign-extends
            left <= left + pos_x_t'(vel_x);
            top  <= top + pos_y_t'(vel_y);
        end
    end

endmodule

// File: sprite_render.sv
`timescale 1ns/1ps

module sprite_render #(
    parameter int          SPRITE_SIZE  = 40,
    parameter int          H_ACTIVE_END = 639,
    parameter int          V_ACTIVE_END = 479,
    parameter logic [11:0] COLOR        = 12'hfff
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              visible,
    input  game_pkg::raster_t h_count,
    input  game_pkg::raster_t v_count,
    input  game_pkg::pos_x_t  left,
    input  game_pkg::pos_y_t  top,
    output logic              valid,
    output game_pkg::chan_t   red,
    output game_pkg::chan_t   grn,
    output game_pkg::chan_t   blu
);

    // 12-bit signed so left+size cannot wrap
    localparam logic signed [11:0] SIZE_S = 12'(SPRITE_SIZE);

    logic signed [11:0] col_s;
    logic signed [11:0] row_s;
    logic signed [11:0] left_s;
    logic signed [11:0] top_s;
    logic               in_active;
    logic               in_box;
    logic               hit;

    assign col_s  = $signed({2'b00, h_count});
    assign row_s  = $signed({2'b00, v_count});
    // sign-extended origin
    assign left_s = {left[10], left};
    assign top_s  = {{2{top[9]}}, top};

    assign in_active = (h_count <= H_ACTIVE_END) && (v_count <= V_ACTIVE_END);

    // half-open box [left, left+size) x [top, top+size)
    assign in_box = (col_s >= left_s) && (col_s < left_s + SIZE_S) &&
                    (row_s >= top_s) && (row_s < top_s + SIZE_S);

    assign hit = visible && in_active && in_box;

    always_ff @(posedge clk)
    begin
        if (reset)
            valid <= 1'b0;
        else
            valid <= hit;
    end

    // solid square in the pose colour, black elsewhere
    always_ff @(posedge clk)
    begin
        red <= hit ? COLOR[11:8] : 4'h0;
        grn <= hit ? COLOR[7:4]  : 4'h0;
        blu <= hit ? COLOR[3:0]  : 4'h0;
    end

endmodule

// File: sprite_game_top.sv
`timescale 1ns/1ps

module sprite_game_top #(
    parameter int          H_ACTIVE_END = 639,
    parameter int          H_FP_END     = 655,
    parameter int          H_SYNC_END   = 751,
    parameter int          H_TOTAL_END  = 799,
    parameter int          V_ACTIVE_END = 479,
    parameter int          V_FP_END     = 489,
    parameter int          V_SYNC_END   = 491,
    parameter int          V_TOTAL_END  = 520,
    parameter int          START_LEFT   = 300,
    parameter int          START_TOP    = 250,
    parameter int          SPRITE_SIZE  = 40,
    parameter logic [11:0] WALK_A_COLOR = 12'hf80,
    parameter logic [11:0] WALK_B_COLOR = 12'h0f8,
    parameter logic [11:0] JUMP_COLOR   = 12'h8af
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            jump_raw,
    input  logic            right_raw,
    input  logic            left_raw,
    input  logic            stop_raw,
    output logic            vga_hs,
    output logic            vga_vs,
    output game_pkg::chan_t vga_r,
    output game_pkg::chan_t vga_g,
    output game_pkg::chan_t vga_b,
    output logic            jumping
);
    import game_pkg::*;

    raster_t h_count;
    raster_t v_count;
    logic    frame_start;
    logic    jump_press;
    logic    right_press;
    logic    left_press;
    logic    stop_press;
    vel_t    vel_y;
    pose_t   pose;
    pos_x_t  sprite_left;
    pos_y_t  sprite_top;

    // one visible bit per renderer
    logic    walk_a_vis;
    logic    walk_b_vis;
    logic    jump_vis;

    logic    walk_a_valid;
    logic    walk_b_valid;
    logic    jump_valid;
    chan_t   walk_a_red;
    chan_t   walk_a_grn;
    chan_t   walk_a_blu;
    chan_t   walk_b_red;
    chan_t   walk_b_grn;
    chan_t   walk_b_blu;
    chan_t   jump_red;
    chan_t   jump_grn;
    chan_t   jump_blu;

    vga_timing #(
        .H_ACTIVE_END (H_ACTIVE_END),
        .H_FP_END     (H_FP_END),
        .H_SYNC_END   (H_SYNC_END),
        .H_TOTAL_END  (H_TOTAL_END),
        .V_ACTIVE_END (V_ACTIVE_END),
        .V_FP_END     (V_FP_END),
        .V_SYNC_END   (V_SYNC_END),
        .V_TOTAL_END  (V_TOTAL_END)
    ) u_vga_timing (
        .clk         (clk),
        .reset       (reset),
        .h_count     (h_count),
        .v_count     (v_count),
        .frame_start (frame_start),
        .hsync       (vga_hs),
        .vsync       (vga_vs)
    );

    button_edges u_button_edges (
        .clk         (clk),
        .reset       (reset),
        .jump_raw    (jump_raw),
        .right_raw   (right_raw),
        .left_raw    (left_raw),
        .stop_raw    (stop_raw),
        .jump_press  (jump_press),
        .right_press (right_press),
        .left_press  (left_press),
        .stop_press  (stop_press)
    );

    jump_control u_jump_control (
        .clk         (clk),
        .reset       (reset),
        .frame_start (frame_start),
        .jump_press  (jump_press),
        .jumping     (jumping),
        .vel_y       (vel_y),
        .pose        (pose)
    );

    sprite_motion #(
        .START_LEFT (START_LEFT),
        .START_TOP  (START_TOP)
    ) u_sprite_motion (
        .clk         (clk),
        .reset       (reset),
        .frame_start (frame_start),
        .right_press (right_press),
        .left_press  (left_press),
        .stop_press  (stop_press),
        .vel_y       (vel_y),
        .left        (sprite_left),
        .top         (sprite_top)
    );

    // pose decode
    assign walk_a_vis = (pose == walk_a);
    assign walk_b_vis = (pose == walk_b);
    assign jump_vis   = (pose == jump);

    // all three poses share one position
    sprite_render #(
        .SPRITE_SIZE  (SPRITE_SIZE),
        .H_ACTIVE_END (H_ACTIVE_END),
        .V_ACTIVE_END (V_ACTIVE_END),
        .COLOR        (WALK_A_COLOR)
    ) u_walk_a (
        .clk     (clk),
        .reset   (reset),
        .visible (walk_a_vis),
        .h_count (h_count),
        .v_count (v_count),
        .left    (sprite_left),
        .top     (sprite_top),
        .valid   (walk_a_valid),
        .red     (walk_a_red),
        .grn     (walk_a_grn),
        .blu     (walk_a_blu)
    );

    sprite_render #(
        .SPRITE_SIZE  (SPRITE_SIZE),
        .H_ACTIVE_END (H_ACTIVE_END),
        .V_ACTIVE_END (V_ACTIVE_END),
        .COLOR        (WALK_B_COLOR)
    ) u_walk_b (
        .clk     (clk),
        .reset   (reset),
        .visible (walk_b_vis),
        .h_count (h_count),
        .v_count (v_count),
        .left    (sprite_left),
        .top     (sprite_top),
        .valid   (walk_b_valid),
        .red     (walk_b_red),
        .grn     (walk_b_grn),
        .blu     (walk_b_blu)
    );

    sprite_render #(
        .SPRITE_SIZE  (SPRITE_SIZE),
        .H_ACTIVE_END (H_ACTIVE_END),
        .V_ACTIVE_END (V_ACTIVE_END),
        .COLOR        (JUMP_COLOR)
    ) u_jump (
        .clk     (clk),
        .reset   (reset),
        .visible (jump_vis),
        .h_count (h_count),
        .v_count (v_count),
        .left    (sprite_left),
        .top     (sprite_top),
        .valid   (jump_valid),
        .red     (jump_red),
        .grn     (jump_grn),
        .blu     (jump_blu)
    );

    // fixed priority: jump over walk_b over walk_a, black background
    always_comb
    begin
        if (jump_valid)
        begin
            vga_r = jump_red;
            vga_g = jump_grn;
            vga_b = jump_blu;
        end
        else if (walk_b_valid)
        begin
            vga_r = walk_b_red;
            vga_g = walk_b_grn;
            vga_b = walk_b_blu;
        end
        else if (walk_a_valid)
        begin
            vga_r = walk_a_red;
            vga_g = walk_a_grn;
            vga_b = walk_a_blu;
        end
        else
        begin
            vga_r = '0;
            vga_g = '0;
            vga_b = '0;
        end
    end

endmodule

// File: sprite_game_tb.sv
`timescale 1ns/1ps

module sprite_game_tb;
    import game_pkg::*;

    localparam int SEED         = 59162;
    localparam int H_ACTIVE_END = 63;
    localparam int H_FP_END     = 65;
    localparam int H_SYNC_END   = 75;
    localparam int H_TOTAL_END  = 79;
    localparam int V_ACTIVE_END = 40;
    localparam int V_FP_END     = 43;
    localparam int V_SYNC_END   = 46;
    localparam int V_TOTAL_END  = 52;
    localparam int START_LEFT   = 10;
    localparam int START_TOP    = 30;
    localparam int SPRITE_SIZE  = 8;
    localparam logic [11:0] WALK_A_COLOR = 12'he21;
    localparam logic [11:0] WALK_B_COLOR = 12'h3c4;
    localparam logic [11:0] JUMP_COLOR   = 12'h59f;
    // frames used by all tests together, with some slack
    localparam int    TEST_FRAMES  = 90;
    localparam int    FRAME_CYCLES = (H_TOTAL_END + 1) * (V_TOTAL_END + 1);
    localparam longint WATCHDOG_NS = (longint'(TEST_FRAMES) * FRAME_CYCLES + 2000) * 8;

    // button codes for press_button
    localparam int BTN_JUMP  = 0;
    localparam int BTN_RIGHT = 1;
    localparam int BTN_LEFT  = 2;
    localparam int BTN_STOP  = 3;

    logic  clk;
    logic  reset;
    logic  jump_raw;
    logic  right_raw;
    logic  left_raw;
    logic  stop_raw;
    logic  vga_hs;
    logic  vga_vs;
    chan_t vga_r;
    chan_t vga_g;
    chan_t vga_b;
    logic  jumping;

    // raster model of the pixel at the output
    int    col;
    int    row;
    logic  have_frame;
    int    error_count;

    // per-frame scan accumulators
    int          acc_count;
    int          acc_row0;
    int          acc_col0;
    int          acc_row1;
    int          acc_col1;
    logic [11:0] acc_rgb;
    logic        acc_mixed;

    // last two finished frames
    int          rec_row_prev;
    int          rec_row_last;
    int          rec_col_prev;
    int          rec_col_last;
    logic [11:0] rec_rgb_last;
    int          mtop_prev;
    int          mtop_last;

    // expected game state
    int    m_left;
    int    m_top;
    int    m_vx;
    int    m_vy;
    logic  m_jumping;
    int    m_jf;
    pose_t m_pose;
    int    m_frame_no;

    sprite_game_top #(
        .H_ACTIVE_END (H_ACTIVE_END),
        .H_FP_END     (H_FP_END),
        .H_SYNC_END   (H_SYNC_END),
        .H_TOTAL_END  (H_TOTAL_END),
        .V_ACTIVE_END (V_ACTIVE_END),
        .V_FP_END     (V_FP_END),
        .V_SYNC_END   (V_SYNC_END),
        .V_TOTAL_END  (V_TOTAL_END),
        .START_LEFT   (START_LEFT),
        .START_TOP    (START_TOP),
        .SPRITE_SIZE  (SPRITE_SIZE),
        .WALK_A_COLOR (WALK_A_COLOR),
        .WALK_B_COLOR (WALK_B_COLOR),
        .JUMP_COLOR   (JUMP_COLOR)
    ) u_sprite_game_top (
        .clk       (clk),
        .reset     (reset),
        .jump_raw  (jump_raw),
        .right_raw (right_raw),
        .left_raw  (left_raw),
        .stop_raw  (stop_raw),
        .vga_hs    (vga_hs),
        .vga_vs    (vga_vs),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b),
        .jumping   (jumping)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // hard stop if the tests stall
    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish in time");
        $display("STATUS: FAIL");
        $fatal(1);
    end

    task automatic stop_on_error();
        error_count = error_count + 1;
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic compare_chan(string name, chan_t got, chan_t exp);
        if (got !== exp)
        begin
            $display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic compare_pos(string name, pos_x_t got, pos_x_t exp);
        if (got !== exp)
        begin
            $display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic compare_level(string name, logic got, logic exp);
        if (got !== exp)
        begin
            $display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic compare_count(string name, int got, int exp);
        if (got != exp)
        begin
            $display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
            stop_on_error();
        end
    endtask

    function automatic logic [11:0] color_of(pose_t p);
        if (p == jump)
            return JUMP_COLOR;
        else if (p == walk_b)
            return WALK_B_COLOR;
        return WALK_A_COLOR;
    endfunction

    function automatic int max_int(int a, int b);
        return (a > b) ? a : b;
    endfunction

    function automatic int min_int(int a, int b);
        return (a < b) ? a : b;
    endfunction

    // game rules applied at each frame_start
    task automatic advance_model();
        logic done;
        logic swap;
        done = 1'b0;
        swap = (m_frame_no % POSE_SWAP_FRAMES) == 0;
        // position takes the velocities held before this frame_start
        m_left = m_left + m_vx;
        m_top  = m_top + m_vy;
        if (!m_jumping)
        begin
            m_jf = 0;
            m_vy = 0;
        end
        else if (m_jf < JUMP_HALF_FRAMES)
        begin
            m_jf = m_jf + 1;
            m_vy = -JUMP_STEP;
        end
        else if (m_jf < 2 * JUMP_HALF_FRAMES)
        begin
            m_jf = m_jf + 1;
            m_vy = JUMP_STEP;
        end
        else
        begin
            m_jf = 0;
            m_vy = 0;
            done = 1'b1;
        end
        if (done)
            m_pose = walk_a;
        else if (swap)
            m_pose = m_jumping ? jump : ((m_pose == walk_a) ? walk_b : walk_a);
        if (done)
            m_jumping = 1'b0;
        m_frame_no = m_frame_no + 1;
    endtask

    // compare the scanned frame with the clipped expected box
    task automatic finish_frame();
        int rlo;
        int rhi;
        int clo;
        int chi;
        int exp_count;
        logic [11:0] exp_rgb;
        rlo = max_int(m_top, 0);
        rhi = min_int(m_top + SPRITE_SIZE, V_ACTIVE_END + 1);
        clo = max_int(m_left, 0);
        chi = min_int(m_left + SPRITE_SIZE, H_ACTIVE_END + 1);
        exp_count = (rhi > rlo && chi > clo) ? (rhi - rlo) * (chi - clo) : 0;
        exp_rgb = color_of(m_pose);
        compare_count("sprite pixel count", acc_count, exp_count);
        if (exp_count > 0)
        begin
            compare_pos("sprite first row", pos_x_t'(acc_row0), pos_x_t'(rlo));
            compare_pos("sprite first col", pos_x_t'(acc_col0), pos_x_t'(clo));
            compare_pos("sprite last row", pos_x_t'(acc_row1), pos_x_t'(rhi - 1));
            compare_pos("sprite last col", pos_x_t'(acc_col1), pos_x_t'(chi - 1));
            compare_chan("vga_r", acc_rgb[11:8], exp_rgb[11:8]);
            compare_chan("vga_g", acc_rgb[7:4], exp_rgb[7:4]);
            compare_chan("vga_b", acc_rgb[3:0], exp_rgb[3:0]);
            compare_level("sprite mixed colour", acc_mixed, 1'b0);
        end
        rec_row_prev = rec_row_last;
        rec_col_prev = rec_col_last;
        rec_row_last = acc_row0;
        rec_col_last = acc_col0;
        rec_rgb_last = acc_rgb;
        mtop_prev    = mtop_last;
        mtop_last    = m_top;
        advance_model();
    endtask

    // one pixel clock; sample on the falling edge
    task automatic step();
        logic [11:0] rgb;
        @(negedge clk);
        if (col == H_TOTAL_END)
        begin
            col = 0;
            row = (row == V_TOTAL_END) ? 0 : row + 1;
        end
        else
        begin
            col = col + 1;
        end
        if (col == 0 && row == 0)
        begin
            if (have_frame)
                finish_frame();
            have_frame = 1'b1;
            acc_count  = 0;
            acc_mixed  = 1'b0;
        end
        // sync low inside the sync window of each counter
        compare_level("vga_hs", vga_hs, !(col > H_FP_END && col <= H_SYNC_END));
        compare_level("vga_vs", vga_vs, !(row > V_FP_END && row <= V_SYNC_END));
        if (col == 10 && row == 0)
            compare_level("jumping", jumping, m_jumping);
        rgb = {vga_r, vga_g, vga_b};
        if (rgb != 12'h000)
        begin
            if (acc_count == 0)
            begin
                acc_row0 = row;
                acc_col0 = col;
                acc_rgb  = rgb;
            end
            else if (rgb != acc_rgb)
            begin
                acc_mixed = 1'b1;
            end
            acc_row1  = row;
            acc_col1  = col;
            acc_count = acc_count + 1;
        end
    endtask

    // lock the raster model on the first hsync fall
    // the output lags the counters by one pixel
    task automatic align_raster();
        @(negedge clk);
        while (vga_hs !== 1'b0)
            @(negedge clk);
        col        = H_FP_END + 1;
        row        = 0;
        have_frame = 1'b1;
        acc_count  = 0;
        acc_mixed  = 1'b0;
        compare_level("vga_vs", vga_vs, 1'b1);
    endtask

    // run until the next frame has been scanned
    task automatic wait_frame();
        step();
        while (!(col == 0 && row == 0))
            step();
    endtask

    task automatic press_button(int which, int len);
        case (which)
            BTN_JUMP:
            begin
                jump_raw = 1'b1;
                if (!m_jumping)
                    m_jumping = 1'b1;
            end
            BTN_RIGHT:
            begin
                right_raw = 1'b1;
                m_vx = WALK_STEP;
            end
            BTN_LEFT:
            begin
                left_raw = 1'b1;
                m_vx = -WALK_STEP;
            end
            default:
            begin
                stop_raw = 1'b1;
                m_vx = 0;
            end
        endcase
        repeat (len) step();
        jump_raw  = 1'b0;
        right_raw = 1'b0;
        left_raw  = 1'b0;
        stop_raw  = 1'b0;
    endtask

    task automatic test_reset_state();
        compare_level("jumping", jumping, 1'b0);
        wait_frame();
        compare_pos("reset left", pos_x_t'(rec_col_last), pos_x_t'(START_LEFT));
        compare_pos("reset top", pos_x_t'(rec_row_last), pos_x_t'(START_TOP));
        compare_chan("reset red", rec_rgb_last[11:8], WALK_A_COLOR[11:8]);
        compare_chan("reset green", rec_rgb_last[7:4], WALK_A_COLOR[7:4]);
        compare_chan("reset blue", rec_rgb_last[3:0], WALK_A_COLOR[3:0]);
    endtask

    task automatic test_walk_animation();
        logic [11:0] last_rgb;
        int          hold;
        logic        seen_change;
        last_rgb    = rec_rgb_last;
        hold        = 0;
        seen_change = 1'b0;
        repeat (2 * POSE_SWAP_FRAMES + 1)
        begin
            wait_frame();
            compare_pos("idle left", pos_x_t'(rec_col_last), pos_x_t'(START_LEFT));
            compare_pos("idle top", pos_x_t'(rec_row_last), pos_x_t'(START_TOP));
            if (rec_rgb_last != last_rgb)
            begin
                // the first swap follows the reset frame
                if (seen_change)
                    compare_count("pose hold frames", hold, POSE_SWAP_FRAMES);
                seen_change = 1'b1;
                hold = 0;
            end
            last_rgb = rec_rgb_last;
            hold = hold + 1;
        end
    endtask

    task automatic test_jump();
        int delta;
        press_button(BTN_JUMP, $urandom_range(1, 6));
        wait_frame();
        while (m_jumping)
        begin
            wait_frame();
            delta = mtop_last - mtop_prev;
            // row step only where the whole box is on screen
            if (mtop_last >= 0 && mtop_prev >= 0)
                compare_pos("jump top step", pos_x_t'(rec_row_last - rec_row_prev),
                            pos_x_t'(delta));
        end
        wait_frame();
        compare_level("jumping", jumping, 1'b0);
        compare_pos("landed top", pos_x_t'(rec_row_last), pos_x_t'(START_TOP));
        compare_chan("landed red", rec_rgb_last[11:8], WALK_A_COLOR[11:8]);
        compare_chan("landed green", rec_rgb_last[7:4], WALK_A_COLOR[7:4]);
        compare_chan("landed blue", rec_rgb_last[3:0], WALK_A_COLOR[3:0]);
    endtask

    task automatic test_walking();
        int choice;
        repeat (6)
        begin
            choice = $urandom_range(BTN_RIGHT, BTN_STOP);
            // keep the box fully on screen
            if (m_left < 16 && choice == BTN_LEFT)
                choice = BTN_RIGHT;
            if (m_left > 40 && choice == BTN_RIGHT)
                choice = BTN_LEFT;
            press_button(choice, $urandom_range(1, 6));
            wait_frame();
            wait_frame();
            wait_frame();
            compare_pos("walk left step", pos_x_t'(rec_col_last - rec_col_prev),
                        pos_x_t'(m_vx));
        end
    endtask

    initial
    begin
        reset       = 1'b1;
        jump_raw    = 1'b0;
        right_raw   = 1'b0;
        left_raw    = 1'b0;
        stop_raw    = 1'b0;
        have_frame  = 1'b0;
        error_count = 0;
        col = 0;
        row = 0;
        acc_count = 0;
        acc_mixed = 1'b0;
        rec_row_last = 0;
        rec_col_last = 0;
        mtop_last  = START_TOP;
        m_left     = START_LEFT;
        m_top      = START_TOP;
        m_vx       = 0;
        m_vy       = 0;
        m_jumping  = 1'b0;
        m_jf       = 0;
        m_pose     = walk_a;
        m_frame_no = 0;
        void'($urandom(SEED));
        repeat (10) @(negedge clk);
        reset = 1'b0;
        // first hsync pulse fixes the raster position
        align_raster();
        test_reset_state();
        test_walk_animation();
        test_jump();
        test_walking();
        if (error_count == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: sprite_game_top.f
game_pkg.sv
vga_timing.sv
button_edges.sv
jump_control.sv
sprite_motion.sv
sprite_render.sv
sprite_game_top.sv
sprite_game_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module sprite_game_tb \
    -f sprite_game_top.f -o sim_sprite_game
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/sim_sprite_game)
sim_status=$?
echo "$output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$output" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1
